//--- video_timing_pkg.sv
package video_timing_pkg;

	////////////////////
	// counter widths
	////////////////////

	// pixel position within a line, 0 to H_TOTAL-1
	typedef logic [8:0] h_count_t;
	// line number within a frame, 0 to V_TOTAL-1
	typedef logic [8:0] v_count_t;
	// master divider phase, one step per 48 MHz cycle
	typedef logic [2:0] div_count_t;

	////////////////////
	// bundled signals
	////////////////////

	// one-cycle strobes at 24, 12 and 6 MHz
	typedef struct packed {
		logic ce_24m;
		logic ce_12m;
		logic ce_6m;
	} clk_enables_t;

	// horizontal sync group, all active low
	typedef struct packed {
		logic hsync_n;
		logic hblank_n;
		logic hreset_n;
	} h_sync_t;

	// vertical sync group, all active low
	typedef struct packed {
		logic vsync_n;
		logic vblank_n;
		logic vreset_n;
	} v_sync_t;

	// horizontal raster bits, s1h/s2h trail h1/h2 by one pixel
	typedef struct packed {
		logic h1;
		logic h2;
		logic h4;
		logic s1h;
		logic s2h;
	} h_bits_t;

	// line count bits 0, 3 and 7 under their board names
	typedef struct packed {
		logic v1;
		logic v4;
		logic v8;
	} v_bits_t;

	////////////////////
	// raster defaults
	////////////////////

	localparam h_count_t H_TOTAL       = 9'd384;
	localparam h_count_t H_BLANK_START = 9'd272;
	localparam h_count_t H_BLANK_END   = 9'd368;
	localparam h_count_t H_SYNC_START  = 9'd304;
	localparam h_count_t H_SYNC_END    = 9'd336;
	localparam h_count_t H_RESET_POS   = 9'd15;

	// vertical blank and sync both wrap through line 0
	localparam v_count_t V_TOTAL       = 9'd264;
	localparam v_count_t V_BLANK_START = 9'd240;
	localparam v_count_t V_BLANK_END   = 9'd16;
	localparam v_count_t V_SYNC_START  = 9'd248;
	localparam v_count_t V_SYNC_END    = 9'd0;

endpackage

//--- clock_enable_gen.sv
`timescale 1ns/1ps

module clock_enable_gen
	import video_timing_pkg::*;
(
	input  logic         CLK_48M,
	input  logic         rst,
	output clk_enables_t enables
);

	////////////////////
	// master divider
	////////////////////

	// free running, wraps every 8 cycles
	div_count_t div;
	// value the divider takes at the next edge
	div_count_t div_next;

	assign div_next = div + 3'd1;

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			div <= '0;
		end else begin
			div <= div_next;
		end
	end

	////////////////////
	// strobe decode
	////////////////////

	// decoded from div_next so each strobe is high
	// in the same cycle as the divider value it marks
	// 6 MHz implies 12 MHz implies 24 MHz
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			enables <= '0;
		end else begin
			// odd phases
			enables.ce_24m <= div_next[0];
			// phases 3 and 7
			enables.ce_12m <= (div_next[1:0] == 2'b11);
			// phase 7 only, one pixel per 8 cycles
			enables.ce_6m  <= (div_next == 3'd7);
		end
	end

endmodule

//--- horizontal_timing.sv
`timescale 1ns/1ps

module horizontal_timing
	import video_timing_pkg::*;
#(
	parameter h_count_t H_TOTAL       = video_timing_pkg::H_TOTAL,
	parameter h_count_t H_BLANK_START = video_timing_pkg::H_BLANK_START,
	parameter h_count_t H_BLANK_END   = video_timing_pkg::H_BLANK_END,
	parameter h_count_t H_SYNC_START  = video_timing_pkg::H_SYNC_START,
	parameter h_count_t H_SYNC_END    = video_timing_pkg::H_SYNC_END,
	parameter h_count_t H_RESET_POS   = video_timing_pkg::H_RESET_POS
)(
	input  logic    CLK_48M,
	input  logic    rst,
	input  logic    pixel_ce,
	output logic    line_step,
	output h_sync_t h_sync,
	output h_bits_t h_bits
);

	// last pixel of a line
	localparam h_count_t H_LAST = H_TOTAL - 9'd1;

	////////////////////
	// pixel counter
	////////////////////

	h_count_t h_count;
	h_count_t h_next;

	// wrap after the last pixel
	assign h_next = (h_count == H_LAST) ? '0 : h_count + 9'd1;

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			h_count <= '0;
		end else if (pixel_ce) begin
			h_count <= h_next;
		end
	end

	////////////////////
	// sync, blank, reset
	////////////////////

	// decoded from h_next so the outputs move with the counter
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			h_sync.hsync_n  <= 1'b1;
			h_sync.hblank_n <= 1'b1;
			h_sync.hreset_n <= 1'b1;
		end else if (pixel_ce) begin
			// blank window, set and cleared at its edges
			if (h_next == H_BLANK_START) begin
				h_sync.hblank_n <= 1'b0;
			end else if (h_next == H_BLANK_END) begin
				h_sync.hblank_n <= 1'b1;
			end

			// sync low from start up to end, end excluded
			if (h_next == H_SYNC_START) begin
				h_sync.hsync_n <= 1'b0;
			end else if (h_next == H_SYNC_END) begin
				h_sync.hsync_n <= 1'b1;
			end

			// single pixel pulse
			h_sync.hreset_n <= (h_next != H_RESET_POS);
		end
	end

	////////////////////
	// line step
	////////////////////

	// one 48 MHz cycle wide, lines up with the hsync_n fall
	// the vertical block counts on this
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			line_step <= 1'b0;
		end else begin
			line_step <= pixel_ce && (h_next == H_SYNC_START);
		end
	end

	////////////////////
	// raster bits
	////////////////////

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			h_bits <= '0;
		end else if (pixel_ce) begin
			// delayed copies take the old h1/h2
			h_bits.s1h <= h_bits.h1;
			h_bits.s2h <= h_bits.h2;
			// 3 MHz
			h_bits.h1  <= h_next[0];
			// 1.5 MHz
			h_bits.h2  <= h_next[1];
			// 750 kHz
			h_bits.h4  <= h_next[2];
		end
	end

endmodule

//--- vertical_timing.sv
`timescale 1ns/1ps

module vertical_timing
	import video_timing_pkg::*;
#(
	parameter v_count_t V_TOTAL       = video_timing_pkg::V_TOTAL,
	parameter v_count_t V_BLANK_START = video_timing_pkg::V_BLANK_START,
	parameter v_count_t V_BLANK_END   = video_timing_pkg::V_BLANK_END,
	parameter v_count_t V_SYNC_START  = video_timing_pkg::V_SYNC_START,
	parameter v_count_t V_SYNC_END    = video_timing_pkg::V_SYNC_END
)(
	input  logic    CLK_48M,
	input  logic    rst,
	input  logic    line_step,
	output v_sync_t v_sync,
	output v_bits_t v_bits
);

	// last line of a frame
	localparam v_count_t V_LAST = V_TOTAL - 9'd1;

	////////////////////
	// line counter
	////////////////////

	v_count_t v_count;
	v_count_t v_next;

	// wrap after the last line
	assign v_next = (v_count == V_LAST) ? '0 : v_count + 9'd1;

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			v_count <= '0;
		end else if (line_step) begin
			v_count <= v_next;
		end
	end

	////////////////////
	// sync and blank
	////////////////////

	// both windows wrap through line 0
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			v_sync.vsync_n  <= 1'b1;
			v_sync.vblank_n <= 1'b1;
		end else if (line_step) begin
			if (v_next == V_BLANK_START) begin
				v_sync.vblank_n <= 1'b0;
			end else if (v_next == V_BLANK_END) begin
				v_sync.vblank_n <= 1'b1;
			end

			if (v_next == V_SYNC_START) begin
				v_sync.vsync_n <= 1'b0;
			end else if (v_next == V_SYNC_END) begin
				v_sync.vsync_n <= 1'b1;
			end
		end
	end

	////////////////////
	// vertical reset
	////////////////////

	// cycles left in the low pulse, one pixel is 8 cycles
	logic [2:0] vreset_stretch;

	// falls on the line step into line 0
	// stays low 8 cycles, then released
	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			v_sync.vreset_n <= 1'b1;
			vreset_stretch  <= '0;
		end else if (line_step && (v_next == '0)) begin
			v_sync.vreset_n <= 1'b0;
			vreset_stretch  <= 3'd7;
		end else if (!v_sync.vreset_n) begin
			if (vreset_stretch == '0) begin
				v_sync.vreset_n <= 1'b1;
			end else begin
				vreset_stretch <= vreset_stretch - 3'd1;
			end
		end
	end

	////////////////////
	// raster bits
	////////////////////

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			v_bits <= '0;
		end else if (line_step) begin
			// line count bits 0, 3, 7
			v_bits.v1 <= v_next[0];
			v_bits.v4 <= v_next[3];
			v_bits.v8 <= v_next[7];
		end
	end

endmodule

//--- video_timing_top.sv
`timescale 1ns/1ps

module video_timing_top
	import video_timing_pkg::*;
#(
	parameter h_count_t H_TOTAL       = video_timing_pkg::H_TOTAL,
	parameter h_count_t H_BLANK_START = video_timing_pkg::H_BLANK_START,
	parameter h_count_t H_BLANK_END   = video_timing_pkg::H_BLANK_END,
	parameter h_count_t H_SYNC_START  = video_timing_pkg::H_SYNC_START,
	parameter h_count_t H_SYNC_END    = video_timing_pkg::H_SYNC_END,
	parameter h_count_t H_RESET_POS   = video_timing_pkg::H_RESET_POS,
	parameter v_count_t V_TOTAL       = video_timing_pkg::V_TOTAL,
	parameter v_count_t V_BLANK_START = video_timing_pkg::V_BLANK_START,
	parameter v_count_t V_BLANK_END   = video_timing_pkg::V_BLANK_END,
	parameter v_count_t V_SYNC_START  = video_timing_pkg::V_SYNC_START,
	parameter v_count_t V_SYNC_END    = video_timing_pkg::V_SYNC_END
)(
	input  logic         CLK_48M,
	input  logic         rst,
	output clk_enables_t enables,
	output h_sync_t      h_sync,
	output v_sync_t      v_sync,
	output h_bits_t      h_bits,
	output v_bits_t      v_bits
);

	// one cycle strobe at each hsync fall
	logic line_step;

	////////////////////
	// clock enables
	////////////////////

	clock_enable_gen u_clock_enable_gen (
		.CLK_48M (CLK_48M),
		.rst     (rst),
		.enables (enables)
	);

	////////////////////
	// horizontal
	////////////////////

	// runs at the 6 MHz pixel rate
	horizontal_timing #(
		.H_TOTAL       (H_TOTAL),
		.H_BLANK_START (H_BLANK_START),
		.H_BLANK_END   (H_BLANK_END),
		.H_SYNC_START  (H_SYNC_START),
		.H_SYNC_END    (H_SYNC_END),
		.H_RESET_POS   (H_RESET_POS)
	) u_horizontal_timing (
		.CLK_48M   (CLK_48M),
		.rst       (rst),
		.pixel_ce  (enables.ce_6m),
		.line_step (line_step),
		.h_sync    (h_sync),
		.h_bits    (h_bits)
	);

	////////////////////
	// vertical
	////////////////////

	// one step per line
	vertical_timing #(
		.V_TOTAL       (V_TOTAL),
		.V_BLANK_START (V_BLANK_START),
		.V_BLANK_END   (V_BLANK_END),
		.V_SYNC_START  (V_SYNC_START),
		.V_SYNC_END    (V_SYNC_END)
	) u_vertical_timing (
		.CLK_48M   (CLK_48M),
		.rst       (rst),
		.line_step (line_step),
		.v_sync    (v_sync),
		.v_bits    (v_bits)
	);

endmodule

//--- tb_video_timing.sv
`timescale 1ns/1ps

module tb_video_timing
	import video_timing_pkg::*;
();

	////////////////////
	// raster numbers
	////////////////////

	localparam int CLK_PERIOD   = 100;
	// one pixel per 8 master cycles
	localparam int PIXEL_CYC    = 8;
	localparam int LINE_CYC     = 384 * PIXEL_CYC;
	localparam int FRAME_LINES  = 264;
	localparam int FRAME_CYC    = FRAME_LINES * LINE_CYC;
	// hsync low 32 pixels
	// hblank leads it by 32 and trails by 64
	localparam int HSYNC_LOW    = 32 * PIXEL_CYC;
	localparam int HBLANK_LEAD  = 32 * PIXEL_CYC;
	localparam int HBLANK_TRAIL = 64 * PIXEL_CYC;
	// hreset at pixel 15 and hsync at pixel 304
	localparam int HRESET_LEAD  = 289 * PIXEL_CYC;
	localparam int WATCHDOG_CYC = 3 * FRAME_CYC;

	localparam logic [2:0] T_STROBE = 3'd0;
	localparam logic [2:0] T_RESET  = 3'd1;
	localparam logic [2:0] T_LINE   = 3'd2;
	localparam logic [2:0] T_FRAME  = 3'd3;
	localparam logic [2:0] T_VRESET = 3'd4;
	localparam logic [2:0] T_RASTER = 3'd5;
	localparam int N_TESTS = 6;

	logic         CLK_48M;
	logic         rst;
	clk_enables_t enables;
	h_sync_t      h_sync;
	v_sync_t      v_sync;
	h_bits_t      h_bits;
	v_bits_t      v_bits;

	// monitor state
	int      cycle = 0;
	logic    checks_on;
	logic    reset_phase;
	int      test_checks [8];
	int      test_errs [8];
	int      n_pass = 0;
	int      n_fail = 0;
	clk_enables_t prev_en;
	h_sync_t prev_hs;
	v_sync_t prev_vs;
	h_bits_t prev_hb;
	v_bits_t prev_vb;
	// edge timestamps in cycles or -1 until first seen
	int ce24_rise = -1;
	int ce12_rise = -1;
	int ce6_rise = -1;
	int hsync_fall = -1;
	int hblank_fall = -1;
	int hreset_fall = -1;
	int vsync_fall = -1;
	int vsync_rise = -1;
	int vblank_fall = -1;
	int vreset_fall = -1;
	int h1_edge = -1;
	int h2_edge = -1;
	int h4_edge = -1;
	// line number as the board would count it
	int tb_line = 0;
	int ce6_rises = 0;
	int hsync_falls = 0;
	int vsync_falls = 0;
	int vblank_rises = 0;
	int vreset_rises = 0;
	int vbit_checks = 0;
	logic vbit_pending = 1'b0;

	video_timing_top UUT (
		.CLK_48M (CLK_48M),
		.rst     (rst),
		.enables (enables),
		.h_sync  (h_sync),
		.v_sync  (v_sync),
		.h_bits  (h_bits),
		.v_bits  (v_bits)
	);

	////////////////////
	// helpers
	////////////////////

	task automatic report_error(input logic [2:0] id, input string msg);
		test_errs[id]++;
		$display("Error at %0d ns: %s", $time, msg);
	endtask

	task automatic expect_true(input logic [2:0] id, input logic ok, input string msg);
		test_checks[id]++;
		assert (ok) else report_error(id, msg);
	endtask

	// distance from an earlier edge once that edge exists
	task automatic expect_gap(input logic [2:0] id, input int from, input int expected,
		input string what);
		if (from >= 0) begin
			expect_true(id, (cycle - from) == expected,
				$sformatf("%s is %0d cycles, expected %0d", what, cycle - from, expected));
		end
	endtask

	function automatic string test_name(input logic [2:0] id);
		case (id)
			T_STROBE: return "enable strobes";
			T_RESET:  return "reset state";
			T_LINE:   return "line timing";
			T_FRAME:  return "frame timing";
			T_VRESET: return "vertical reset";
			default:  return "raster bits";
		endcase
	endfunction

	function automatic logic test_ok(input logic [2:0] id);
		return (test_errs[id] == 0) && (test_checks[id] > 0);
	endfunction

	task automatic print_result(input logic [2:0] id);
		$display("test %s: %s, %0d checks, %0d errors", test_name(id),
			test_ok(id) ? "pass" : "fail", test_checks[id], test_errs[id]);
	endtask

	task automatic tally(input logic [2:0] id);
		if (test_ok(id)) begin
			n_pass++;
		end else begin
			n_fail++;
		end
	endtask

	////////////////////
	// clock, cycle count, watchdog
	////////////////////

	initial begin
		CLK_48M = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_48M = ~CLK_48M;
	end

	always @(posedge CLK_48M) begin
		cycle <= cycle + 1;
	end

	// three frames where the checks need just over two
	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("timeout: the tests did not complete within three frames");
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////
	// concurrent checks
	////////////////////

	// slower strobes nest inside faster ones
	assert property (@(negedge CLK_48M) disable iff (!checks_on)
		enables.ce_6m |-> enables.ce_12m)
		else report_error(T_STROBE, "ce_6m without ce_12m");
	assert property (@(negedge CLK_48M) disable iff (!checks_on)
		enables.ce_12m |-> enables.ce_24m)
		else report_error(T_STROBE, "ce_12m without ce_24m");

	// delayed copies trail by one pixel
	assert property (@(negedge CLK_48M) disable iff (!checks_on)
		h_bits.s1h == $past(h_bits.h1, PIXEL_CYC))
		else report_error(T_RASTER, "s1h is not h1 from one pixel earlier");
	assert property (@(negedge CLK_48M) disable iff (!checks_on)
		h_bits.s2h == $past(h_bits.h2, PIXEL_CYC))
		else report_error(T_RASTER, "s2h is not h2 from one pixel earlier");

	////////////////////
	// edge monitor
	////////////////////

	// outputs move on the rising edge and are sampled on the falling one
	always @(negedge CLK_48M) begin
		if (!h_sync.hsync_n && prev_hs.hsync_n) begin
			tb_line = (tb_line + 1) % FRAME_LINES;
		end

		if (reset_phase) begin
			expect_true(T_RESET, h_sync == 3'b111 && v_sync == 3'b111,
				"sync outputs not inactive around reset");
			expect_true(T_RESET, h_bits == '0 && v_bits == '0,
				"raster bits not zero around reset");
		end

		if (checks_on) begin
			// strobe period and one cycle width
			if (enables.ce_24m && !prev_en.ce_24m) begin
				expect_gap(T_STROBE, ce24_rise, 2, "ce_24m period");
				ce24_rise = cycle;
			end
			if (enables.ce_12m && !prev_en.ce_12m) begin
				expect_gap(T_STROBE, ce12_rise, 4, "ce_12m period");
				ce12_rise = cycle;
			end
			if (enables.ce_6m && !prev_en.ce_6m) begin
				expect_gap(T_STROBE, ce6_rise, 8, "ce_6m period");
				ce6_rise = cycle;
				ce6_rises++;
			end
			expect_true(T_STROBE, !(enables & prev_en), "enable strobe wider than one cycle");

			// line timing
			if (!h_sync.hblank_n && prev_hs.hblank_n) begin
				hblank_fall = cycle;
			end
			if (!h_sync.hreset_n && prev_hs.hreset_n) begin
				expect_gap(T_LINE, hreset_fall, LINE_CYC, "hreset_n period");
				hreset_fall = cycle;
			end
			if (h_sync.hreset_n && !prev_hs.hreset_n) begin
				expect_gap(T_LINE, hreset_fall, PIXEL_CYC, "hreset_n low time");
			end

			// v bits settle the cycle after an hsync fall
			if (vbit_pending) begin
				expect_true(T_RASTER, v_bits.v1 == tb_line[0] && v_bits.v4 == tb_line[3]
					&& v_bits.v8 == tb_line[7],
					$sformatf("line %0d has v1/v4/v8 = %b%b%b", tb_line,
					v_bits.v1, v_bits.v4, v_bits.v8));
				vbit_checks++;
				vbit_pending = 1'b0;
			end

			if (!h_sync.hsync_n && prev_hs.hsync_n) begin
				expect_gap(T_LINE, hsync_fall, LINE_CYC, "hsync_n period");
				expect_gap(T_LINE, hblank_fall, HBLANK_LEAD, "hblank_n fall to hsync_n fall");
				expect_gap(T_LINE, hreset_fall, HRESET_LEAD, "hreset_n fall to hsync_n fall");
				hsync_fall = cycle;
				hsync_falls++;
				vbit_pending = 1'b1;
			end
			if (h_sync.hsync_n && !prev_hs.hsync_n) begin
				expect_gap(T_LINE, hsync_fall, HSYNC_LOW, "hsync_n low time");
			end
			if (h_sync.hblank_n && !prev_hs.hblank_n) begin
				expect_gap(T_LINE, hsync_fall, HBLANK_TRAIL, "hsync_n fall to hblank_n rise");
			end

			// every vertical sync and blank edge rides on a line step
			if (v_sync.vsync_n != prev_vs.vsync_n || v_sync.vblank_n != prev_vs.vblank_n) begin
				expect_true(T_FRAME, cycle == hsync_fall + 1,
					"vertical edge not one cycle after hsync_n fall");
			end
			if (!v_sync.vblank_n && prev_vs.vblank_n) begin
				vblank_fall = cycle;
			end
			if (!v_sync.vsync_n && prev_vs.vsync_n) begin
				expect_gap(T_FRAME, vsync_fall, FRAME_CYC, "vsync_n period");
				expect_gap(T_FRAME, vblank_fall, 8 * LINE_CYC, "vblank_n fall to vsync_n fall");
				vsync_fall = cycle;
				vsync_falls++;
			end
			if (v_sync.vsync_n && !prev_vs.vsync_n) begin
				expect_gap(T_FRAME, vsync_fall, 16 * LINE_CYC, "vsync_n low time");
				vsync_rise = cycle;
			end
			if (v_sync.vblank_n && !prev_vs.vblank_n) begin
				expect_gap(T_FRAME, vblank_fall, 40 * LINE_CYC, "vblank_n low time");
				vblank_rises++;
			end

			// vertical reset at the start of line 0
			if (!v_sync.vreset_n && prev_vs.vreset_n) begin
				expect_true(T_VRESET, cycle == hsync_fall + 1,
					"vreset_n fall not one cycle after hsync_n fall");
				expect_true(T_VRESET, cycle == vsync_rise,
					"vreset_n fall not on the line where vsync_n rises");
				expect_gap(T_VRESET, vreset_fall, FRAME_CYC, "vreset_n period");
				vreset_fall = cycle;
			end
			if (v_sync.vreset_n && !prev_vs.vreset_n) begin
				expect_gap(T_VRESET, vreset_fall, PIXEL_CYC, "vreset_n low time");
				vreset_rises++;
			end

			// toggle spacing of the h raster bits
			if (h_bits.h1 != prev_hb.h1) begin
				expect_gap(T_RASTER, h1_edge, PIXEL_CYC, "h1 toggle spacing");
				h1_edge = cycle;
			end
			if (h_bits.h2 != prev_hb.h2) begin
				expect_gap(T_RASTER, h2_edge, 2 * PIXEL_CYC, "h2 toggle spacing");
				h2_edge = cycle;
			end
			if (h_bits.h4 != prev_hb.h4) begin
				expect_gap(T_RASTER, h4_edge, 4 * PIXEL_CYC, "h4 toggle spacing");
				h4_edge = cycle;
			end
			if (v_bits != prev_vb) begin
				expect_true(T_RASTER, cycle == hsync_fall + 1,
					"v raster bits changed away from a line step");
			end
		end

		prev_en = enables;
		prev_hs = h_sync;
		prev_vs = v_sync;
		prev_hb = h_bits;
		prev_vb = v_bits;
	end

	////////////////////
	// stimulus and summary
	////////////////////

	initial begin
		rst = 1'b1;
		checks_on = 1'b0;
		reset_phase = 1'b1;

		// rst changes on the falling edge so three rising edges see it high
		repeat (3) @(negedge CLK_48M);
		rst = 1'b0;
		// keep the reset check through the first cycle after release
		repeat (2) @(posedge CLK_48M);
		reset_phase = 1'b0;
		print_result(T_RESET);

		// let $past history fill before the monitor starts
		repeat (16) @(posedge CLK_48M);
		checks_on = 1'b1;

		wait (ce6_rises >= 64);
		print_result(T_STROBE);
		wait (hsync_falls >= 4);
		print_result(T_LINE);
		// two pulses so the frame period is measured
		wait (vreset_rises >= 2);
		print_result(T_VRESET);
		wait (vbit_checks >= FRAME_LINES + 8);
		print_result(T_RASTER);
		wait (vsync_falls >= 2 && vblank_rises >= 1);
		print_result(T_FRAME);

		repeat (4) @(posedge CLK_48M);
		for (int i = 0; i < N_TESTS; i++) begin
			tally(i[2:0]);
		end
		$display("summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- vlog.f
video_timing_pkg.sv
clock_enable_gen.sv
horizontal_timing.sv
vertical_timing.sv
video_timing_top.sv
tb_video_timing.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the video timing testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

TOP=tb_video_timing
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module "$TOP" \
	-f vlog.f \
	-o "$TOP"

./obj_dir/"$TOP" | tee "$LOG"

if grep -qx '\*\*\* PASSED \*\*\*' "$LOG"; then
	echo "run_sim: pass"
	exit 0
else
	echo "run_sim: fail, see $LOG"
	exit 1
fi
